// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_datapath
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
verilog/mips_pkg.sv
verilog/pipe_if.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/retire.sv
verilog/datapath.sv
tb/tb_datapath.sv

// ==== tb/tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath;
    import mips_pkg::*;

    localparam int PROG_LEN     = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = PROG_LEN * 10 + RESET_CYCLES + 344;
    localparam int FAST_FIRST   = 16;   // zero-delay fetch window.
    localparam int FAST_LAST    = 39;
    localparam int SEED         = 32'h68c8;
    localparam int HALF_PERIOD  = 20;
    localparam int DRIVE_DELAY  = 2;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    word_t     iaddr;
    logic      ireq;
    logic      iack = 1'b0;
    word_t     idata = '0;
    logic      rt_valid;
    word_t     rt_pc;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    word_t     prog [PROG_LEN];
    word_t     model_regs [32];
    integer    seed;
    int        cycles = 0;
    int        retired = 0;
    int        fetches = 0;
    int        ack_wait = -1;
    logic      ireq_prev = 1'b0;
    word_t     exp_pc = RESET_PC;
    word_t     cur_instr;
    logic      exp_we;
    reg_addr_t exp_dst;
    word_t     exp_val;

    datapath dut0 (
        .clk(clk), .rst(rst),
        .iaddr(iaddr), .ireq(ireq), .iack(iack), .idata(idata),
        .rt_valid(rt_valid), .rt_pc(rt_pc),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t program_word(input word_t addr);
        if (addr < 32'(PROG_LEN * 4))
            return prog[addr[7:2]];
        else
            return '0;   // past the program.
    endfunction

    // ============================================================
    // program generation
    // ============================================================
    function automatic word_t make_instr(input int kind);
        reg_addr_t   s, t, d;
        logic [15:0] imm;
        word_t       w;
        s   = reg_addr_t'(rand_below(8));   // few registers, many dependencies.
        t   = reg_addr_t'(rand_below(8));
        d   = reg_addr_t'(rand_below(8));
        imm = 16'($random(seed));
        case (kind)
            0:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_ADDU};
            1:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_SUBU};
            2:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_AND};
            3:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_OR};
            4:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_XOR};
            5:       w = {OPC_SPECIAL, s, t, d, 5'd0, FN_SLT};
            6:       w = {OPC_ADDIU, s, t, imm};
            7:       w = {OPC_ORI, s, t, imm};
            8:       w = {OPC_LUI, 5'd0, t, imm};
            default: begin
                case (rand_below(3))
                    0:       w = '0;
                    1:       w = {OPC_SPECIAL, s, t, d, 5'd0, 6'h20};   // trapping add.
                    default: w = {6'h23, s, t, imm};                   // load word.
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic build_program();
        int kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i < 10)
                kind = (i + 6) % 10;   // every form once up front.
            else
                kind = rand_below(10);
            prog[i] = make_instr(kind);
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================
    function automatic void model_exec(input word_t instr, output logic we,
                                       output reg_addr_t dst, output word_t val);
        logic [5:0]  opc, fn;
        reg_addr_t   s, t, d;
        logic [15:0] imm;
        word_t       x, y;
        logic        known;
        opc   = instr[31:26];
        s     = instr[25:21];
        t     = instr[20:16];
        d     = instr[15:11];
        fn    = instr[5:0];
        imm   = instr[15:0];
        x     = model_regs[s];
        y     = model_regs[t];
        known = 1'b1;
        dst   = t;
        val   = '0;
        case (opc)
            OPC_SPECIAL: begin
                dst = d;
                case (fn)
                    FN_ADDU: val = x + y;
                    FN_SUBU: val = x - y;
                    FN_AND:  val = x & y;
                    FN_OR:   val = x | y;
                    FN_XOR:  val = x ^ y;
                    FN_SLT:  val = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
                    default: known = 1'b0;
                endcase
            end
            OPC_ADDIU: val = x + {{16{imm[15]}}, imm};
            OPC_ORI:   val = x | {16'h0000, imm};
            OPC_LUI:   val = {imm, 16'h0000};
            default:   known = 1'b0;
        endcase
        we = known && (dst != 5'd0);
        if (we) model_regs[dst] = val;
    endfunction

    // ============================================================
    // instruction memory
    // ============================================================
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (rst) begin
            iack      = 1'b0;
            idata     = '0;
            ack_wait  = -1;
            ireq_prev = 1'b0;
        end else begin
            if (ireq && !ireq_prev && iack) begin
                $display("protocol error: ireq raised again while iack was still high");
                abort_run();
            end
            if (!ireq && ireq_prev && !iack) begin
                $display("protocol error: ireq dropped before iack was given");
                abort_run();
            end
            if (ireq && !iack) begin
                if (ack_wait < 0)
                    ack_wait = (fetches >= FAST_FIRST && fetches <= FAST_LAST) ?
                               0 : rand_below(4);
                if (ack_wait == 0) begin
                    check_value("iaddr", iaddr, 32'(fetches * 4));
                    iack     = 1'b1;
                    idata    = program_word(iaddr);
                    ack_wait = -1;
                    fetches++;
                end else begin
                    ack_wait--;
                end
            end else if (!ireq && iack) begin
                iack = 1'b0;
            end
            ireq_prev = ireq;
        end
    end

    // ============================================================
    // checks
    // ============================================================
    always @(negedge clk) begin
        if (rst && cycles > 0) begin
            check_value("ireq", 32'(ireq), 32'h0);
            check_value("rt_valid", 32'(rt_valid), 32'h0);
            check_value("rf_we", 32'(rf_we), 32'h0);
        end
    end

    always @(negedge clk) begin
        if (!rst && rt_valid) begin
            cur_instr = program_word(exp_pc);
            model_exec(cur_instr, exp_we, exp_dst, exp_val);
            check_value("rt_pc", rt_pc, exp_pc);
            check_value("rf_we", 32'(rf_we), 32'(exp_we));
            if (exp_we) begin
                check_value("rf_waddr", 32'(rf_waddr), 32'(exp_dst));
                check_value("rf_wdata", rf_wdata, exp_val);
            end
            exp_pc = exp_pc + 32'd4;
            retired++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired, PROG_LEN);
            abort_run();
        end
    end

    initial begin
        seed = SEED;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_value("iaddr", iaddr, RESET_PC);
        check_value("ireq", 32'(ireq), 32'h0);
        check_value("rt_valid", 32'(rt_valid), 32'h0);
        check_value("rf_we", 32'(rf_we), 32'h0);
        wait (retired == PROG_LEN);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic                clk,
    input  logic                rst,
    output mips_pkg::word_t     iaddr,
    output logic                ireq,
    input  logic                iack,
    input  mips_pkg::word_t     idata,
    output logic                rt_valid,
    output mips_pkg::word_t     rt_pc,
    output logic                rf_we,
    output mips_pkg::reg_addr_t rf_waddr,
    output mips_pkg::word_t     rf_wdata
);
    import mips_pkg::*;

    logic      f_valid;
    word_t     f_instr, f_pc;
    reg_addr_t raddr0, raddr1;
    word_t     rdata0, rdata1;
    logic      wb_we;       // commit-cycle write.
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    issue_if  issue ();
    commit_if commit ();

    // ============================================================
    // input side
    // ============================================================
    fetch fetch0 (
        .clk(clk), .rst(rst),
        .iaddr(iaddr), .ireq(ireq), .iack(iack), .idata(idata),
        .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc)
    );

    // ============================================================
    // decode, register file, execute
    // ============================================================
    decode decode0 (
        .clk(clk), .rst(rst),
        .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc),
        .raddr0(raddr0), .raddr1(raddr1), .rdata0(rdata0), .rdata1(rdata1),
        .issue(issue)
    );

    regfile regfile0 (
        .clk(clk), .rst(rst),
        .raddr0(raddr0), .raddr1(raddr1), .rdata0(rdata0), .rdata1(rdata1),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata)
    );

    execute execute0 (.clk(clk), .rst(rst), .issue(issue), .commit(commit));

    // ============================================================
    // output side
    // ============================================================
    retire retire0 (
        .clk(clk), .rst(rst), .commit(commit),
        .rf_we(wb_we), .rf_waddr(wb_waddr), .rf_wdata(wb_wdata),
        .rt_valid(rt_valid), .rt_pc(rt_pc),
        .rt_we(rf_we), .rt_waddr(rf_waddr), .rt_wdata(rf_wdata)
    );

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                f_valid,
    input  mips_pkg::word_t     f_instr,
    input  mips_pkg::word_t     f_pc,
    output mips_pkg::reg_addr_t raddr0,
    output mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::word_t     rdata0,
    input  mips_pkg::word_t     rdata1,
    issue_if.src                issue
);
    import mips_pkg::*;

    opcode_t    opc;
    logic [5:0] funct;
    reg_addr_t  rs, rt, rd;
    logic [15:0] imm;
    alu_op_t    op;
    logic       use_rs, use_rt;
    reg_addr_t  dest;
    word_t      imm_ext;

    assign opc   = f_instr[OPC_LSB +: 6];
    assign rs    = f_instr[RS_LSB +: 5];
    assign rt    = f_instr[RT_LSB +: 5];
    assign rd    = f_instr[RD_LSB +: 5];
    assign funct = f_instr[5:0];
    assign imm   = f_instr[15:0];

    assign raddr0 = rs;
    assign raddr1 = rt;

    always_comb begin
        op      = ALU_NONE;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        dest    = 5'd0;
        imm_ext = '0;
        case (opc)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU: op = ALU_ADDU;
                    FN_SUBU: op = ALU_SUBU;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    default: op = ALU_NONE;
                endcase
                if (op != ALU_NONE) begin
                    use_rs = 1'b1;
                    use_rt = 1'b1;
                    dest   = rd;
                end
            end
            OPC_ADDIU: begin
                op      = ALU_ADDIU;
                use_rs  = 1'b1;
                dest    = rt;
                imm_ext = {{16{imm[15]}}, imm};   // sign extend.
            end
            OPC_ORI: begin
                op      = ALU_ORI;
                use_rs  = 1'b1;
                dest    = rt;
                imm_ext = {16'h0000, imm};
            end
            OPC_LUI: begin
                op      = ALU_LUI;
                dest    = rt;
                imm_ext = {imm, 16'h0000};
            end
            default: op = ALU_NONE;
        endcase
    end

    // ============================================================
    // issue register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) issue.valid <= 1'b0;
        else     issue.valid <= f_valid;
    end

    always_ff @(posedge clk) begin
        issue.op <= op;
        issue.rd <= dest;
        issue.rs <= use_rs ? rs : 5'd0;
        issue.rt <= use_rt ? rt : 5'd0;
        issue.a  <= rdata0;
        issue.b  <= use_rt ? rdata1 : imm_ext;
        issue.pc <= f_pc;
    end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic  clk,
    input  logic  rst,
    issue_if.dst  issue,
    commit_if.src commit
);
    import mips_pkg::*;

    logic  hit_a, hit_b;
    word_t a, b;
    word_t result;
    logic  wr_en;

    // ============================================================
    // bypass from the instruction one ahead
    // ============================================================
    assign hit_a = commit.valid && commit.we && (commit.rd == issue.rs);
    assign hit_b = commit.valid && commit.we && (commit.rd == issue.rt);
    assign a     = hit_a ? commit.result : issue.a;
    assign b     = hit_b ? commit.result : issue.b;

    always_comb begin
        case (issue.op)
            ALU_ADDU, ALU_ADDIU: result = a + b;
            ALU_SUBU:            result = a - b;
            ALU_AND:             result = a & b;
            ALU_OR, ALU_ORI:     result = a | b;
            ALU_XOR:             result = a ^ b;
            ALU_SLT:             result = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI:             result = b;   // already shifted.
            default:             result = '0;
        endcase
    end

    // nothing lands in r0 or from an unknown encoding.
    assign wr_en = (issue.op != ALU_NONE) && (issue.rd != 5'd0);

    // ============================================================
    // execute register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
            commit.we    <= 1'b0;
        end else begin
            commit.valid <= issue.valid;
            commit.we    <= issue.valid && wr_en;
        end
    end

    always_ff @(posedge clk) begin
        commit.rd     <= issue.rd;
        commit.result <= result;
        commit.pc     <= issue.pc;
    end

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ps

module fetch (
    input  logic            clk,
    input  logic            rst,
    output mips_pkg::word_t iaddr,
    output logic            ireq,
    input  logic            iack,
    input  mips_pkg::word_t idata,
    output logic            f_valid,
    output mips_pkg::word_t f_instr,
    output mips_pkg::word_t f_pc
);
    import mips_pkg::*;

    fetch_state_t state;
    word_t        pc;
    logic         capture;

    assign iaddr   = pc;
    assign capture = (state == FETCH_REQ) && ireq && iack;

    // ============================================================
    // four-phase handshake
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            pc      <= RESET_PC;
            ireq    <= 1'b0;
            f_valid <= 1'b0;
        end else begin
            f_valid <= 1'b0;
            case (state)
                FETCH_IDLE: state <= FETCH_REQ;
                FETCH_REQ: begin
                    if (capture) begin
                        ireq    <= 1'b0;
                        f_valid <= 1'b1;
                        pc      <= pc + 32'd4;
                        state   <= FETCH_RELEASE;
                    end else begin
                        ireq <= 1'b1;
                    end
                end
                FETCH_RELEASE: begin
                    if (!iack) state <= FETCH_REQ;   // memory dropped ack.
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            f_instr <= idata;
            f_pc    <= pc;
        end
    end

endmodule

// ==== verilog/mips_pkg.sv ====
package mips_pkg;

    // ============================================================
    // basic types
    // ============================================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_ADDIU,
        ALU_ORI,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_RELEASE
    } fetch_state_t;

    // ============================================================
    // instruction fields
    // ============================================================
    localparam int OPC_LSB = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;

    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_ADDIU   = 6'h09;
    localparam opcode_t OPC_ORI     = 6'h0d;
    localparam opcode_t OPC_LUI     = 6'h0f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== verilog/pipe_if.sv ====
`timescale 1ns/1ps

// decode -> execute.
interface issue_if;
    import mips_pkg::*;

    logic      valid;
    alu_op_t   op;
    reg_addr_t rd;     // destination register.
    reg_addr_t rs;     // zero when a is not a register read.
    reg_addr_t rt;     // zero when b is not a register read.
    word_t     a;
    word_t     b;
    word_t     pc;

    modport src (output valid, op, rd, rs, rt, a, b, pc);
    modport dst (input  valid, op, rd, rs, rt, a, b, pc);
endinterface

// execute -> retire, also the bypass source.
interface commit_if;
    import mips_pkg::*;

    logic      valid;
    logic      we;
    reg_addr_t rd;
    word_t     result;
    word_t     pc;

    modport src (output valid, we, rd, result, pc);
    modport dst (input  valid, we, rd, result, pc);
endinterface

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t raddr0,
    input  mips_pkg::reg_addr_t raddr1,
    output mips_pkg::word_t     rdata0,
    output mips_pkg::word_t     rdata1,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);
    import mips_pkg::*;

    word_t regs [1:31];   // r0 is not stored.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = (raddr0 == 5'd0)        ? '0    :
                    (we && waddr == raddr0) ? wdata :   // write-through.
                                              regs[raddr0];
    assign rdata1 = (raddr1 == 5'd0)        ? '0    :
                    (we && waddr == raddr1) ? wdata :
                                              regs[raddr1];

endmodule

// ==== verilog/retire.sv ====
`timescale 1ns/1ps

module retire (
    input  logic                clk,
    input  logic                rst,
    commit_if.dst               commit,
    output logic                rf_we,
    output mips_pkg::reg_addr_t rf_waddr,
    output mips_pkg::word_t     rf_wdata,
    output logic                rt_valid,
    output mips_pkg::word_t     rt_pc,
    output logic                rt_we,
    output mips_pkg::reg_addr_t rt_waddr,
    output mips_pkg::word_t     rt_wdata
);
    import mips_pkg::*;

    // register file write, taken at the end of the commit cycle.
    assign rf_we    = commit.valid && commit.we;
    assign rf_waddr = commit.rd;
    assign rf_wdata = commit.result;

    // trace lines up with the register file update.
    always_ff @(posedge clk) begin
        if (rst) begin
            rt_valid <= 1'b0;
            rt_we    <= 1'b0;
        end else begin
            rt_valid <= commit.valid;
            rt_we    <= rf_we;
        end
    end

    always_ff @(posedge clk) begin
        rt_pc    <= commit.pc;
        rt_waddr <= rf_waddr;
        rt_wdata <= rf_wdata;
    end

endmodule
